/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module cpu_tb -f verilog.f -o cpu_sim \
    && ./obj_dir/cpu_sim > sim.log 2>&1
cat sim.log
grep -qF '*** TEST PASSED ***' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* src/alu.sv */
module alu (
    input  cpu_pkg::alu_op_t alu_op,
    input  logic             use_imm,
    input  cpu_pkg::word_t   rs_data,
    input  cpu_pkg::word_t   rt_data,
    input  cpu_pkg::word_t   imm_value,
    output cpu_pkg::word_t   alu_result,
    output logic             equal
);

    cpu_pkg::word_t operand_b;

    assign operand_b = use_imm ? imm_value : rt_data;

    always_comb begin
        case (alu_op)
            cpu_pkg::alu_add:    alu_result = rs_data + operand_b;
            cpu_pkg::alu_sub:    alu_result = rs_data - operand_b;
            cpu_pkg::alu_and:    alu_result = rs_data & operand_b;
            cpu_pkg::alu_or:     alu_result = rs_data | operand_b;
            cpu_pkg::alu_not:    alu_result = ~rs_data;
            cpu_pkg::alu_pass_b: alu_result = operand_b;
            default:             alu_result = '0;
        endcase
    end

    // registers only, never the immediate
    assign equal = (rs_data == rt_data);

endmodule

/* src/cpu.sv */
module cpu #(
    parameter cpu_pkg::word_t reset_pc = '0
) (
    input  logic           clk,
    input  logic           reset_n,
    input  cpu_pkg::word_t data1,
    input  logic           m1_ready,
    output logic           read_m1,
    output cpu_pkg::word_t address1,
    output cpu_pkg::word_t num_inst,
    output cpu_pkg::word_t output_port,
    output logic           is_halted
);

    logic                  load_ir;
    logic                  commit;
    cpu_pkg::reg_addr_t    rs_addr;
    cpu_pkg::reg_addr_t    rt_addr;
    cpu_pkg::reg_addr_t    write_addr;
    cpu_pkg::alu_op_t      alu_op;
    logic                  use_imm;
    cpu_pkg::word_t        imm_value;
    cpu_pkg::branch_t      branch_kind;
    cpu_pkg::jump_target_t jump_target;
    logic                  reg_write;
    logic                  wwd;
    logic                  halt;
    cpu_pkg::word_t        rs_data;
    cpu_pkg::word_t        rt_data;
    cpu_pkg::word_t        alu_result;
    logic                  equal;

    cpu_control u_control (
        .clk       (clk),
        .reset_n   (reset_n),
        .m1_ready  (m1_ready),
        .halt      (halt),
        .read_m1   (read_m1),
        .load_ir   (load_ir),
        .commit    (commit),
        .is_halted (is_halted)
    );

    // pc is the fetch address
    program_counter #(
        .reset_pc (reset_pc)
    ) u_pc (
        .clk         (clk),
        .reset_n     (reset_n),
        .commit      (commit),
        .branch_kind (branch_kind),
        .equal       (equal),
        .imm_value   (imm_value),
        .jump_target (jump_target),
        .pc          (address1),
        .num_inst    (num_inst)
    );

    instruction_decoder u_decoder (
        .clk         (clk),
        .reset_n     (reset_n),
        .load_ir     (load_ir),
        .data1       (data1),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .write_addr  (write_addr),
        .alu_op      (alu_op),
        .use_imm     (use_imm),
        .imm_value   (imm_value),
        .branch_kind (branch_kind),
        .jump_target (jump_target),
        .reg_write   (reg_write),
        .wwd         (wwd),
        .halt        (halt)
    );

    register_file u_regs (
        .clk         (clk),
        .reset_n     (reset_n),
        .commit      (commit),
        .reg_write   (reg_write),
        .wwd         (wwd),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .write_addr  (write_addr),
        .alu_result  (alu_result),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .output_port (output_port)
    );

    alu u_alu (
        .alu_op     (alu_op),
        .use_imm    (use_imm),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .imm_value  (imm_value),
        .alu_result (alu_result),
        .equal      (equal)
    );

endmodule

/* src/cpu_control.sv */
module cpu_control (
    input  logic clk,
    input  logic reset_n,
    input  logic m1_ready,
    input  logic halt,
    output logic read_m1,
    output logic load_ir,
    output logic commit,
    output logic is_halted
);

    typedef enum logic [1:0] {
        st_fetch,
        st_execute,
        st_halted
    } cpu_state_t;

    cpu_state_t state;
    cpu_state_t next_state;

    //////////////////////////////
    // next state
    //////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            st_fetch: begin
                if (m1_ready) begin
                    next_state = st_execute;    // instruction arrives on this edge
                end
            end
            st_execute: begin
                if (halt) begin
                    next_state = st_halted;
                end else begin
                    next_state = st_fetch;
                end
            end
            st_halted: begin
                next_state = st_halted;         // only reset leaves
            end
            default: begin
                next_state = st_fetch;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            state <= st_fetch;
        end else begin
            state <= next_state;
        end
    end

    //////////////////////////////
    // outputs
    //////////////////////////////

    // request is held off while reset is asserted
    assign read_m1   = (state == st_fetch) && !reset_n;
    assign load_ir   = read_m1 && m1_ready;
    assign commit    = (state == st_execute);
    assign is_halted = (state == st_halted);

endmodule

/* src/cpu_pkg.sv */
package cpu_pkg;

    //////////////////////////////
    // word types
    //////////////////////////////

    typedef logic [15:0] word_t;        // data, address, instruction
    typedef logic [1:0]  reg_addr_t;
    typedef logic [2:0]  alu_op_t;
    typedef logic [1:0]  branch_t;
    typedef logic [11:0] jump_target_t;

    //////////////////////////////
    // instruction fields
    //////////////////////////////

    localparam int op_msb     = 15;
    localparam int op_lsb     = 12;
    localparam int rs_msb     = 11;
    localparam int rs_lsb     = 10;
    localparam int rt_msb     = 9;
    localparam int rt_lsb     = 8;
    localparam int rd_msb     = 7;
    localparam int rd_lsb     = 6;
    localparam int func_msb   = 5;
    localparam int func_lsb   = 0;
    localparam int imm_msb    = 7;
    localparam int target_msb = 11;

    // opcodes
    localparam logic [3:0] op_bne   = 4'd0;
    localparam logic [3:0] op_beq   = 4'd1;
    localparam logic [3:0] op_adi   = 4'd4;
    localparam logic [3:0] op_ori   = 4'd5;
    localparam logic [3:0] op_lhi   = 4'd6;
    localparam logic [3:0] op_jmp   = 4'd9;
    localparam logic [3:0] op_rtype = 4'd15;

    // func field of r-type
    localparam logic [5:0] fn_add = 6'd0;
    localparam logic [5:0] fn_sub = 6'd1;
    localparam logic [5:0] fn_and = 6'd2;
    localparam logic [5:0] fn_orr = 6'd3;
    localparam logic [5:0] fn_not = 6'd4;
    localparam logic [5:0] fn_wwd = 6'd28;
    localparam logic [5:0] fn_hlt = 6'd29;

    // alu operations
    localparam alu_op_t alu_add    = 3'd0;
    localparam alu_op_t alu_sub    = 3'd1;
    localparam alu_op_t alu_and    = 3'd2;
    localparam alu_op_t alu_or     = 3'd3;
    localparam alu_op_t alu_not    = 3'd4;
    localparam alu_op_t alu_pass_b = 3'd5;  // lhi

    // pc sequencing kinds
    localparam branch_t br_none = 2'd0;
    localparam branch_t br_beq  = 2'd1;
    localparam branch_t br_bne  = 2'd2;
    localparam branch_t br_jump = 2'd3;

endpackage

/* src/instruction_decoder.sv */
module instruction_decoder (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  load_ir,
    input  cpu_pkg::word_t        data1,
    output cpu_pkg::reg_addr_t    rs_addr,
    output cpu_pkg::reg_addr_t    rt_addr,
    output cpu_pkg::reg_addr_t    write_addr,
    output cpu_pkg::alu_op_t      alu_op,
    output logic                  use_imm,
    output cpu_pkg::word_t        imm_value,
    output cpu_pkg::branch_t      branch_kind,
    output cpu_pkg::jump_target_t jump_target,
    output logic                  reg_write,
    output logic                  wwd,
    output logic                  halt
);

    cpu_pkg::word_t ir;
    logic [3:0]     opcode;
    logic [5:0]     func;
    logic [7:0]     imm;
    cpu_pkg::word_t imm_sext;
    cpu_pkg::word_t imm_zext;
    cpu_pkg::word_t imm_high;

    always_ff @(posedge clk) begin
        if (reset_n) begin
            ir <= '0;
        end else if (load_ir) begin
            ir <= data1;
        end
    end

    //////////////////////////////
    // fields
    //////////////////////////////

    assign opcode      = ir[cpu_pkg::op_msb:cpu_pkg::op_lsb];
    assign func        = ir[cpu_pkg::func_msb:cpu_pkg::func_lsb];
    assign imm         = ir[cpu_pkg::imm_msb:0];
    assign rs_addr     = ir[cpu_pkg::rs_msb:cpu_pkg::rs_lsb];
    assign rt_addr     = ir[cpu_pkg::rt_msb:cpu_pkg::rt_lsb];
    assign jump_target = ir[cpu_pkg::target_msb:0];

    assign imm_sext = {{8{imm[7]}}, imm};   // adi, branches
    assign imm_zext = {8'h00, imm};         // ori
    assign imm_high = {imm, 8'h00};         // lhi

    //////////////////////////////
    // control
    //////////////////////////////

    always_comb begin
        write_addr  = ir[cpu_pkg::rd_msb:cpu_pkg::rd_lsb];
        alu_op      = cpu_pkg::alu_add;
        use_imm     = 1'b0;
        imm_value   = imm_sext;
        branch_kind = cpu_pkg::br_none;
        reg_write   = 1'b0;
        wwd         = 1'b0;
        halt        = 1'b0;
        case (opcode)
            cpu_pkg::op_rtype: begin
                reg_write = 1'b1;
                case (func)
                    cpu_pkg::fn_add: alu_op = cpu_pkg::alu_add;
                    cpu_pkg::fn_sub: alu_op = cpu_pkg::alu_sub;
                    cpu_pkg::fn_and: alu_op = cpu_pkg::alu_and;
                    cpu_pkg::fn_orr: alu_op = cpu_pkg::alu_or;
                    cpu_pkg::fn_not: alu_op = cpu_pkg::alu_not;
                    default:         reg_write = 1'b0;
                endcase
                wwd  = (func == cpu_pkg::fn_wwd);
                halt = (func == cpu_pkg::fn_hlt);
            end
            cpu_pkg::op_adi, cpu_pkg::op_ori, cpu_pkg::op_lhi: begin
                write_addr = rt_addr;
                use_imm    = 1'b1;
                reg_write  = 1'b1;
                if (opcode == cpu_pkg::op_ori) begin
                    alu_op    = cpu_pkg::alu_or;
                    imm_value = imm_zext;
                end else if (opcode == cpu_pkg::op_lhi) begin
                    alu_op    = cpu_pkg::alu_pass_b;
                    imm_value = imm_high;
                end
            end
            cpu_pkg::op_beq: branch_kind = cpu_pkg::br_beq;
            cpu_pkg::op_bne: branch_kind = cpu_pkg::br_bne;
            cpu_pkg::op_jmp: branch_kind = cpu_pkg::br_jump;
            default: ;  // counted no-op
        endcase
    end

endmodule

/* src/program_counter.sv */
module program_counter #(
    parameter cpu_pkg::word_t reset_pc = '0
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  commit,
    input  cpu_pkg::branch_t      branch_kind,
    input  logic                  equal,
    input  cpu_pkg::word_t        imm_value,
    input  cpu_pkg::jump_target_t jump_target,
    output cpu_pkg::word_t        pc,
    output cpu_pkg::word_t        num_inst
);

    cpu_pkg::word_t pc_plus_one;
    cpu_pkg::word_t branch_addr;
    cpu_pkg::word_t jump_addr;
    cpu_pkg::word_t next_pc;

    assign pc_plus_one = pc + 16'd1;
    assign branch_addr = pc_plus_one + imm_value;   // imm already sign extended
    assign jump_addr   = {pc[15:12], jump_target};

    // branches resolve here, nothing is predicted
    always_comb begin
        case (branch_kind)
            cpu_pkg::br_beq:  next_pc = equal ? branch_addr : pc_plus_one;
            cpu_pkg::br_bne:  next_pc = equal ? pc_plus_one : branch_addr;
            cpu_pkg::br_jump: next_pc = jump_addr;
            default:          next_pc = pc_plus_one;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_n) begin
            pc       <= reset_pc;
            num_inst <= '0;
        end else if (commit) begin
            pc       <= next_pc;
            num_inst <= num_inst + 16'd1;   // every retired instruction counts
        end
    end

endmodule

/* src/register_file.sv */
module register_file (
    input  logic               clk,
    input  logic               reset_n,
    input  logic               commit,
    input  logic               reg_write,
    input  logic               wwd,
    input  cpu_pkg::reg_addr_t rs_addr,
    input  cpu_pkg::reg_addr_t rt_addr,
    input  cpu_pkg::reg_addr_t write_addr,
    input  cpu_pkg::word_t     alu_result,
    output cpu_pkg::word_t     rs_data,
    output cpu_pkg::word_t     rt_data,
    output cpu_pkg::word_t     output_port
);

    cpu_pkg::word_t regs [4];

    // two combinational read ports
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    always_ff @(posedge clk) begin
        if (reset_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (commit && reg_write) begin
            regs[write_addr] <= alu_result;
        end
    end

    // output port register, loaded by wwd
    always_ff @(posedge clk) begin
        if (reset_n) begin
            output_port <= '0;
        end else if (commit && wwd) begin
            output_port <= rs_data;
        end
    end

endmodule

/* test/cpu_checker.sv */
module cpu_checker #(
    parameter cpu_pkg::word_t reset_pc = '0
) (
    input  logic           clk,
    input  logic           reset_n,
    input  cpu_pkg::word_t data1,
    input  logic           m1_ready,
    input  logic           read_m1,
    input  cpu_pkg::word_t address1,
    input  cpu_pkg::word_t num_inst,
    input  cpu_pkg::word_t output_port,
    input  logic           is_halted,
    output int             errors
);

    typedef struct packed {
        cpu_pkg::word_t    pc;
        logic [3:0] [15:0] regs;
        cpu_pkg::word_t    outp;
        cpu_pkg::word_t    count;
        logic              halted;
    } model_t;

    model_t model;
    logic   exec_due;
    logic   check_due;

    // reference: one instruction applied to the model state
    function automatic model_t next_state(model_t m, cpu_pkg::word_t instr);
        model_t         n;
        logic [1:0]     rs;
        logic [1:0]     rt;
        logic [1:0]     rd;
        cpu_pkg::word_t a;
        cpu_pkg::word_t b;
        cpu_pkg::word_t sext;
        cpu_pkg::word_t seq;
        n    = m;
        rs   = instr[11:10];
        rt   = instr[9:8];
        rd   = instr[7:6];
        a    = m.regs[rs];
        b    = m.regs[rt];
        sext = {{8{instr[7]}}, instr[7:0]};
        seq  = m.pc + 16'd1;
        n.pc    = seq;
        n.count = m.count + 16'd1;
        case (instr[15:12])
            cpu_pkg::op_rtype: begin
                case (instr[5:0])
                    cpu_pkg::fn_add: n.regs[rd] = a + b;
                    cpu_pkg::fn_sub: n.regs[rd] = a - b;
                    cpu_pkg::fn_and: n.regs[rd] = a & b;
                    cpu_pkg::fn_orr: n.regs[rd] = a | b;
                    cpu_pkg::fn_not: n.regs[rd] = ~a;
                    cpu_pkg::fn_wwd: n.outp = a;
                    cpu_pkg::fn_hlt: n.halted = 1'b1;
                    default: ;
                endcase
            end
            cpu_pkg::op_adi: n.regs[rt] = a + sext;
            cpu_pkg::op_ori: n.regs[rt] = a | {8'h00, instr[7:0]};
            cpu_pkg::op_lhi: n.regs[rt] = {instr[7:0], 8'h00};
            cpu_pkg::op_beq: if (a == b) n.pc = seq + sext;
            cpu_pkg::op_bne: if (a != b) n.pc = seq + sext;
            cpu_pkg::op_jmp: n.pc = {m.pc[15:12], instr[11:0]};
            default: ;
        endcase
        return n;
    endfunction

    task automatic compare_word(input string name, input cpu_pkg::word_t exp,
                                input cpu_pkg::word_t act);
        if (exp !== act) begin
            $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    initial errors = 0;

    //////////////////////////////
    // compare
    //////////////////////////////

    always @(posedge clk) begin
        if (reset_n) begin
            model     = '0;
            model.pc  = reset_pc;
            exec_due  = 1'b0;
            check_due = 1'b0;
        end else begin
            if (check_due) begin    // one cycle after the execute edge
                compare_word("output_port", model.outp, output_port);
                compare_word("num_inst", model.count, num_inst);
                compare_word("is_halted", {15'd0, model.halted}, {15'd0, is_halted});
                compare_word("read_m1", {15'd0, !model.halted}, {15'd0, read_m1});
                check_due = 1'b0;
            end
            if (exec_due) begin     // execute cycle
                if (read_m1) begin
                    $display("error at %0t: read_m1 stayed high in the execute cycle", $time);
                    errors++;
                end
                exec_due  = 1'b0;
                check_due = 1'b1;
            end
            if (read_m1 && model.halted) begin
                $display("error at %0t: instruction fetch requested after HLT", $time);
                errors++;
            end
            if (read_m1 && m1_ready) begin
                compare_word("address1", model.pc, address1);
                model    = next_state(model, data1);
                exec_due = 1'b1;
            end
        end
    end

endmodule

/* test/cpu_sva.sv */
module cpu_sva (
    input logic           clk,
    input logic           reset_n,
    input logic           read_m1,
    input logic           m1_ready,
    input cpu_pkg::word_t address1,
    input cpu_pkg::word_t num_inst,
    input logic           is_halted
);

    // request held until the memory answers
    a_address_stable: assert property (@(posedge clk) disable iff (reset_n)
        read_m1 && !m1_ready |=> $stable(address1))
        else $error("address1 changed while waiting for m1_ready");

    // halted is final, nothing fetched or counted
    a_no_fetch_halted: assert property (@(posedge clk) disable iff (reset_n)
        is_halted |=> is_halted && !read_m1 && $stable(num_inst))
        else $error("fetch or count change while halted");

    // count moves by one, only after an execute cycle
    a_count_grows: assert property (@(posedge clk) disable iff (reset_n)
        $changed(num_inst) |->
            num_inst == $past(num_inst) + 16'd1 && $past(!read_m1 && !is_halted))
        else $error("num_inst changed outside a commit");

endmodule

bind cpu cpu_sva sva (.*);

/* test/cpu_tb.sv */
module cpu_tb;

    localparam int num_tests  = 6;
    localparam int max_exec   = 24;     // longest program, counted in executed instructions
    localparam int max_delay  = 7;
    localparam int idle_after = 10;     // cycles watched after halt
    localparam int test_limit = max_exec * (max_delay + 2) + 4 + idle_after;
    localparam int run_limit  = num_tests * test_limit + 50;

    logic           clk;
    logic           reset_n;
    cpu_pkg::word_t data1;
    logic           m1_ready;
    logic           read_m1;
    cpu_pkg::word_t address1;
    cpu_pkg::word_t num_inst;
    cpu_pkg::word_t output_port;
    logic           is_halted;
    int             errors;

    cpu_pkg::word_t prog [256];
    int             delay_max;
    int             wait_cnt;
    int             cycle_count;
    int             failed;

    cpu uut (
        .clk         (clk),
        .reset_n     (reset_n),
        .data1       (data1),
        .m1_ready    (m1_ready),
        .read_m1     (read_m1),
        .address1    (address1),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted)
    );

    cpu_checker chk (
        .clk         (clk),
        .reset_n     (reset_n),
        .data1       (data1),
        .m1_ready    (m1_ready),
        .read_m1     (read_m1),
        .address1    (address1),
        .num_inst    (num_inst),
        .output_port (output_port),
        .is_halted   (is_halted),
        .errors      (errors)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= run_limit) begin
            $display("run stopped after %0d cycles, the cycle limit was reached", cycle_count);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    //////////////////////////////
    // program memory
    //////////////////////////////

    always @(posedge clk) begin
        if (read_m1 && m1_ready) begin
            wait_cnt = (delay_max == 0) ? 0 : $urandom_range(delay_max, 0); // next fetch
        end
        #2;
        if (read_m1 && wait_cnt == 0) begin
            m1_ready = 1'b1;
            data1    = prog[address1[7:0]];
        end else begin
            if (read_m1) wait_cnt--;
            m1_ready = 1'b0;
        end
    end

    function automatic cpu_pkg::word_t rtype_word(logic [1:0] rs, logic [1:0] rt,
                                                  logic [1:0] rd, logic [5:0] fn);
        return {cpu_pkg::op_rtype, rs, rt, rd, fn};
    endfunction

    function automatic cpu_pkg::word_t itype_word(logic [3:0] op, logic [1:0] rs,
                                                  logic [1:0] rt, logic [7:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic load_program(input int kind);
        for (int i = 0; i < 256; i++) begin
            prog[i] = {8'hb0, 8'(i)};   // opcode 11, a no-op
        end
        case (kind)
            0: begin    // r-type
                prog[0]  = itype_word(cpu_pkg::op_lhi, 2'd0, 2'd1, 8'h12);
                prog[1]  = itype_word(cpu_pkg::op_ori, 2'd1, 2'd1, 8'h34);
                prog[2]  = itype_word(cpu_pkg::op_lhi, 2'd0, 2'd2, 8'h0f);
                prog[3]  = itype_word(cpu_pkg::op_ori, 2'd2, 2'd2, 8'hf0);
                prog[4]  = rtype_word(2'd1, 2'd2, 2'd3, cpu_pkg::fn_add);
                prog[5]  = rtype_word(2'd3, 2'd0, 2'd0, cpu_pkg::fn_wwd);
                prog[6]  = rtype_word(2'd1, 2'd2, 2'd3, cpu_pkg::fn_sub);
                prog[7]  = rtype_word(2'd3, 2'd0, 2'd0, cpu_pkg::fn_wwd);
                prog[8]  = rtype_word(2'd1, 2'd2, 2'd3, cpu_pkg::fn_and);
                prog[9]  = rtype_word(2'd3, 2'd0, 2'd0, cpu_pkg::fn_wwd);
                prog[10] = rtype_word(2'd1, 2'd2, 2'd3, cpu_pkg::fn_orr);
                prog[11] = rtype_word(2'd3, 2'd0, 2'd0, cpu_pkg::fn_wwd);
                prog[12] = rtype_word(2'd1, 2'd0, 2'd0, cpu_pkg::fn_not);
                prog[13] = rtype_word(2'd0, 2'd0, 2'd0, cpu_pkg::fn_wwd);
                prog[14] = rtype_word(2'd0, 2'd0, 2'd0, cpu_pkg::fn_hlt);
            end
            1: begin    // immediates, negative adi too
                prog[0]  = itype_word(cpu_pkg::op_lhi, 2'd0, 2'd0, 8'h80);
                prog[1]  = rtype_word(2'd0, 2'd0, 2'd0, cpu_pkg::fn_wwd);
                prog[2]  = itype_word(cpu_pkg::op_ori, 2'd0, 2'd1, 8'hff);
                prog[3]  = rtype_word(2'd1, 2'd0, 2'd0, cpu_pkg::fn_wwd);
                prog[4]  = itype_word(cpu_pkg::op_adi, 2'd1, 2'd2, 8'hfb);
                prog[5]  = rtype_word(2'd2, 2'd0, 2'd0, cpu_pkg::fn_wwd);
                prog[6]  = itype_word(cpu_pkg::op_adi, 2'd3, 2'd3, 8'h7f);
                prog[7]  = rtype_word(2'd3, 2'd0, 2'd0, cpu_pkg::fn_wwd);
                prog[8]  = itype_word(cpu_pkg::op_adi, 2'd3, 2'd3, 8'h80);
                prog[9]  = rtype_word(2'd3, 2'd0, 2'd0, cpu_pkg::fn_wwd);
                prog[10] = rtype_word(2'd0, 2'd0, 2'd0, cpu_pkg::fn_hlt);
            end
            default: begin  // branches and jump
                prog[0]  = itype_word(cpu_pkg::op_ori, 2'd0, 2'd1, 8'h03);
                prog[1]  = itype_word(cpu_pkg::op_adi, 2'd1, 2'd1, 8'hff);
                prog[2]  = rtype_word(2'd1, 2'd0, 2'd0, cpu_pkg::fn_wwd);
                prog[3]  = itype_word(cpu_pkg::op_bne, 2'd1, 2'd0, 8'hfd);     // back to 1
                prog[4]  = itype_word(cpu_pkg::op_beq, 2'd1, 2'd0, 8'h02);     // on to 7
                prog[5]  = itype_word(cpu_pkg::op_adi, 2'd2, 2'd2, 8'h11);
                prog[6]  = rtype_word(2'd2, 2'd0, 2'd0, cpu_pkg::fn_wwd);
                prog[7]  = itype_word(cpu_pkg::op_ori, 2'd0, 2'd2, 8'h01);
                prog[8]  = itype_word(cpu_pkg::op_beq, 2'd1, 2'd2, 8'h01);     // not taken
                prog[9]  = itype_word(cpu_pkg::op_bne, 2'd1, 2'd0, 8'h05);     // not taken
                prog[10] = {cpu_pkg::op_jmp, 12'h040};
                prog[11] = rtype_word(2'd0, 2'd0, 2'd0, cpu_pkg::fn_hlt);
                prog[64] = rtype_word(2'd2, 2'd0, 2'd0, cpu_pkg::fn_wwd);
                prog[65] = itype_word(4'd3, 2'd2, 2'd2, 8'h55);
                prog[66] = rtype_word(2'd2, 2'd2, 2'd2, 6'd7);
                prog[67] = rtype_word(2'd2, 2'd0, 2'd0, cpu_pkg::fn_wwd);  // r2 left alone
                prog[68] = rtype_word(2'd0, 2'd0, 2'd0, cpu_pkg::fn_hlt);
            end
        endcase
    endtask

    task automatic run_test(input int id, input string name, input int delay);
        int errors_before;
        int cycles;
        errors_before = errors;
        cycles = 0;
        load_program(id % 3);
        delay_max = delay;
        @(posedge clk);
        #1 reset_n = 1'b1;
        wait_cnt = 0;
        repeat (4) @(posedge clk);
        #1 reset_n = 1'b0;
        while (!is_halted && cycles < test_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (!is_halted) begin
            $display("test %0d %s: the program never reached HLT", id, name);
            failed++;
        end else begin
            repeat (idle_after) @(posedge clk);
            #1;
            if (errors != errors_before) failed++;
            $display("test %0d %s: %0d errors, %0d instructions", id, name,
                     errors - errors_before, num_inst);
        end
    endtask

    initial begin
        void'($urandom(32'hbba54cdb));
        clk         = 1'b0;
        reset_n     = 1'b1;
        data1       = '0;
        m1_ready    = 1'b0;
        delay_max   = 0;
        wait_cnt    = 0;
        cycle_count = 0;
        failed      = 0;
        run_test(0, "r-type", 0);
        run_test(1, "immediate", 0);
        run_test(2, "sequencing", 0);
        run_test(3, "r-type, random ready", max_delay);
        run_test(4, "immediate, random ready", max_delay);
        run_test(5, "sequencing, random ready", max_delay);
        $display("tests %0d, failed %0d, errors %0d", num_tests, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* verilog.f */
src/cpu_pkg.sv
src/cpu_control.sv
src/program_counter.sv
src/instruction_decoder.sv
src/register_file.sv
src/alu.sv
src/cpu.sv
test/cpu_checker.sv
test/cpu_sva.sv
test/cpu_tb.sv
